// File: src/bus_map_pkg.sv
package bus_map_pkg;

    // cpu memory bus word types
    typedef logic [31:0] cpu_addr_t;
    typedef logic [31:0] cpu_data_t;
    // one strobe bit per byte lane
    typedef logic [3:0]  cpu_wstrb_t;

    // 4 KB I/O window
    // only bits 31..12 take part in the compare
    localparam cpu_addr_t io_space_base = 32'h0000_1000;

    // SDRAM window
    // decoded on bits 31..29 only, so it is mirrored across 512 MB
    localparam cpu_addr_t sdram_space_base = 32'h4000_0000;

    // register offsets inside the I/O window
    // trace byte, goes out to the UART
    localparam logic [11:0] io_off_trace = 12'h000;
    // background colour for the video side, 24-bit rgb
    localparam logic [11:0] io_off_bg_color = 12'h004;

    // which target the current access was steered to
    // kept registered in the arbiter for the read mux
    typedef enum logic [1:0] {
        target_bootrom = 2'd0,
        target_io      = 2'd1,
        target_sdram   = 2'd2
    } mem_target_t;

endpackage

// File: src/sdram_xfer_pkg.sv
package sdram_xfer_pkg;

    // one SDRAM data beat
    typedef logic [15:0] half_t;

    // halfword address on the controller port
    // cpu word address with the half select as bit 0
    typedef logic [23:0] sdram_addr_t;

    // two halves of a cpu word, high half in the upper bits
    typedef struct packed {
        half_t hi;
        half_t lo;
    } half_pair_t;

    // same 32 bits, seen as one word or as two halves
    typedef union packed {
        logic [31:0] word;
        half_pair_t  halves;
    } cpu_word_u;

    // strobe patterns the sequencer knows about
    // full word write, two transfers
    localparam logic [3:0] wstrb_full    = 4'b1111;
    // low halfword write, one transfer at bit 0 = 0
    localparam logic [3:0] wstrb_lo_half = 4'b0011;
    // high halfword write, one transfer at bit 0 = 1
    localparam logic [3:0] wstrb_hi_half = 4'b1100;

    // wait cycles after raising rd/wr
    // one to reach the controller, one for rdy to fall
    // rdy is not looked at before these have passed
    localparam logic [1:0] sdram_settle_cycles = 2'd2;

endpackage

// File: src/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
    input  logic                    clk_sys,
    input  logic                    reset_n,
    input  logic                    cpu_valid_i,
    input  bus_map_pkg::cpu_addr_t  cpu_addr_i,
    input  bus_map_pkg::cpu_wstrb_t cpu_wstrb_i,
    input  bus_map_pkg::cpu_data_t  rom_data_i,
    input  bus_map_pkg::cpu_data_t  io_rdata_i,
    input  logic                    seq_done_i,
    input  bus_map_pkg::cpu_data_t  seq_rdata_i,
    output logic                    cpu_ready_o,
    output bus_map_pkg::cpu_data_t  cpu_rdata_o,
    output logic                    seq_start_o,
    output logic                    io_wr_o
);
    import bus_map_pkg::*;

    // three states only, keeps the io write decode shallow
    localparam logic [1:0] st_idle       = 2'd0;
    localparam logic [1:0] st_sdram_wait = 2'd1;
    localparam logic [1:0] st_finished   = 2'd2;

    logic [1:0]  state;
    mem_target_t target_q;
    logic        is_io_addr;
    logic        is_sdram_addr;

    // region decode, upper address bits only
    assign is_io_addr    = (cpu_addr_i[31:12] == io_space_base[31:12]);
    assign is_sdram_addr = (cpu_addr_i[31:29] == sdram_space_base[31:29]);

    // io write strobe
    // io_regs takes it on the same edge that raises ready
    assign io_wr_o = (state == st_idle) && cpu_valid_i && is_io_addr
                     && (cpu_wstrb_i != '0);

    always_ff @(posedge clk_sys) begin
        // both are single cycle pulses
        cpu_ready_o <= 1'b0;
        seq_start_o <= 1'b0;

        if (!reset_n) begin
            state    <= st_idle;
            target_q <= target_bootrom;
        end else begin
            case (state)
                st_idle: begin
                    if (cpu_valid_i) begin
                        if (is_io_addr) begin
                            // io answers right away
                            cpu_ready_o <= 1'b1;
                            target_q    <= target_io;
                            state       <= st_finished;
                        end else if (is_sdram_addr) begin
                            // hand over to the halfword sequencer
                            seq_start_o <= 1'b1;
                            target_q    <= target_sdram;
                            state       <= st_sdram_wait;
                        end else begin
                            // everything else is boot rom
                            // writes just get acknowledged
                            cpu_ready_o <= 1'b1;
                            target_q    <= target_bootrom;
                            state       <= st_finished;
                        end
                    end
                end

                st_sdram_wait: begin
                    // ready one cycle after the sequencer is done
                    if (seq_done_i) begin
                        cpu_ready_o <= 1'b1;
                        state       <= st_finished;
                    end
                end

                st_finished: begin
                    // master drops valid here
                    state <= st_idle;
                end

                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // read data follows the registered target
    always_comb begin
        case (target_q)
            target_io:    cpu_rdata_o = io_rdata_i;
            target_sdram: cpu_rdata_o = seq_rdata_i;
            default:      cpu_rdata_o = rom_data_i;
        endcase
    end

endmodule

// File: src/sdram_halfword_seq.sv
`timescale 1ns/1ps

module sdram_halfword_seq (
    input  logic                        clk_sys,
    input  logic                        reset_n,
    input  logic                        seq_start_i,
    input  bus_map_pkg::cpu_addr_t      cpu_addr_i,
    input  bus_map_pkg::cpu_data_t      cpu_wdata_i,
    input  bus_map_pkg::cpu_wstrb_t     cpu_wstrb_i,
    input  sdram_xfer_pkg::half_t       sdram_rdata_i,
    input  logic                        sdram_rdy_i,
    output logic                        seq_done_o,
    output bus_map_pkg::cpu_data_t      seq_rdata_o,
    output logic                        sdram_rd_o,
    output logic                        sdram_wr_o,
    output sdram_xfer_pkg::sdram_addr_t sdram_addr_o,
    output sdram_xfer_pkg::half_t       sdram_wdata_o,
    output logic                        sdram_ack_o
);
    import sdram_xfer_pkg::*;

    localparam logic [2:0] st_idle     = 3'd0;
    // level up, settle count, then wait for rdy
    localparam logic [2:0] st_xfer     = 3'd1;
    // ack between the two halves of a word
    localparam logic [2:0] st_half_ack = 3'd2;
    localparam logic [2:0] st_finish   = 3'd3;
    localparam logic [2:0] st_tail     = 3'd4;

    logic [2:0] state;
    logic [1:0] settle_cnt;
    // access kind, latched on start
    logic       full_q;
    logic       read_q;

    logic       wr_full;
    logic       wr_lo;
    logic       wr_hi;
    logic       is_read;
    logic       xfer_ready;
    logic       first_half;

    cpu_word_u  wdata_u;
    cpu_word_u  rdata_u;

    // strobe classification
    assign wr_full = (cpu_wstrb_i == wstrb_full);
    assign wr_lo   = (cpu_wstrb_i == wstrb_lo_half);
    assign wr_hi   = (cpu_wstrb_i == wstrb_hi_half);
    // odd strobe patterns fall back to a full word read
    assign is_read = !(wr_full || wr_lo || wr_hi);

    // settle time over and controller says ready
    assign xfer_ready = (settle_cnt == sdram_settle_cycles) && sdram_rdy_i;
    // low half of a two-transfer access still running
    assign first_half = full_q && !sdram_addr_o[0];

    // cpu holds wdata until ready, no copy needed
    assign wdata_u     = cpu_wdata_i;
    assign seq_rdata_o = rdata_u.word;

    always_ff @(posedge clk_sys) begin
        seq_done_o  <= 1'b0;
        sdram_ack_o <= 1'b0;

        if (!reset_n) begin
            state      <= st_idle;
            settle_cnt <= '0;
            full_q     <= 1'b0;
            read_q     <= 1'b0;
            sdram_rd_o <= 1'b0;
            sdram_wr_o <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    settle_cnt <= '0;
                    if (seq_start_i) begin
                        full_q     <= is_read || wr_full;
                        read_q     <= is_read;
                        sdram_rd_o <= is_read;
                        sdram_wr_o <= !is_read;
                        state      <= st_xfer;
                    end
                end

                st_xfer: begin
                    if (settle_cnt != sdram_settle_cycles) begin
                        settle_cnt <= settle_cnt + 2'd1;
                    end else if (sdram_rdy_i) begin
                        // transfer done, drop the level
                        sdram_rd_o <= 1'b0;
                        sdram_wr_o <= 1'b0;
                        if (first_half) begin
                            sdram_ack_o <= 1'b1;
                            state       <= st_half_ack;
                        end else begin
                            state <= st_finish;
                        end
                    end
                end

                st_half_ack: begin
                    // high half goes out after the ack
                    settle_cnt <= '0;
                    sdram_rd_o <= read_q;
                    sdram_wr_o <= !read_q;
                    state      <= st_xfer;
                end

                st_finish: begin
                    seq_done_o <= 1'b1;
                    state      <= st_tail;
                end

                st_tail: begin
                    // trailing ack, controller sees the access closed
                    sdram_ack_o <= 1'b1;
                    state       <= st_idle;
                end

                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // address, write half and read assembly
    always_ff @(posedge clk_sys) begin
        if (state == st_idle && seq_start_i) begin
            // only a lone high half write starts at bit 0 = 1
            sdram_addr_o  <= {cpu_addr_i[24:2], wr_hi};
            sdram_wdata_o <= wr_hi ? wdata_u.halves.hi : wdata_u.halves.lo;
        end else if (state == st_half_ack) begin
            sdram_addr_o[0] <= 1'b1;
            sdram_wdata_o   <= wdata_u.halves.hi;
        end

        if (state == st_xfer && xfer_ready && read_q) begin
            if (sdram_addr_o[0]) begin
                rdata_u.halves.hi <= sdram_rdata_i;
            end else begin
                rdata_u.halves.lo <= sdram_rdata_i;
            end
        end
    end

endmodule

// File: src/io_regs.sv
`timescale 1ns/1ps

module io_regs (
    input  logic                   clk_sys,
    input  logic                   reset_n,
    input  logic                   io_wr_i,
    input  logic [11:0]            io_offset_i,
    input  bus_map_pkg::cpu_data_t io_wdata_i,
    input  logic                   uart_busy_i,
    output bus_map_pkg::cpu_data_t io_rdata_o,
    output logic                   uart_wr_strobe_o,
    output logic [7:0]             uart_data_o,
    output logic [7:0]             led_o,
    output logic [23:0]            bg_color_o
);
    import bus_map_pkg::*;

    logic trace_wr;

    assign trace_wr = io_wr_i && (io_offset_i == io_off_trace);

    always_ff @(posedge clk_sys) begin
        // one cycle strobe to the uart
        uart_wr_strobe_o <= 1'b0;

        if (!reset_n) begin
            bg_color_o <= '0;
        end else begin
            if (trace_wr) begin
                uart_wr_strobe_o <= 1'b1;
            end
            // zero write keeps the old colour
            if (io_wr_i && io_offset_i == io_off_bg_color && io_wdata_i != '0) begin
                bg_color_o <= io_wdata_i[23:0];
            end
        end
    end

    // trace byte, held until the next trace write
    always_ff @(posedge clk_sys) begin
        if (trace_wr) begin
            uart_data_o <= io_wdata_i[7:0];
        end
    end

    // leds show the last traced byte
    assign led_o = uart_data_o;

    // status word, busy flag in bit 0
    assign io_rdata_o = {31'd0, uart_busy_i};

endmodule

// File: src/mem_bridge_top.sv
`timescale 1ns/1ps

module mem_bridge_top (
    input  logic                        clk_sys,
    input  logic                        reset_n,
    input  logic                        cpu_valid_i,
    input  bus_map_pkg::cpu_addr_t      cpu_addr_i,
    input  bus_map_pkg::cpu_data_t      cpu_wdata_i,
    input  bus_map_pkg::cpu_wstrb_t     cpu_wstrb_i,
    input  bus_map_pkg::cpu_data_t      rom_data_i,
    input  logic                        uart_busy_i,
    input  sdram_xfer_pkg::half_t       sdram_rdata_i,
    input  logic                        sdram_rdy_i,
    output logic                        cpu_ready_o,
    output bus_map_pkg::cpu_data_t      cpu_rdata_o,
    output logic                        uart_wr_strobe_o,
    output logic [7:0]                  uart_data_o,
    output logic [7:0]                  led_o,
    output logic [23:0]                 bg_color_o,
    output logic                        sdram_rd_o,
    output logic                        sdram_wr_o,
    output sdram_xfer_pkg::sdram_addr_t sdram_addr_o,
    output sdram_xfer_pkg::half_t       sdram_wdata_o,
    output logic                        sdram_ack_o
);
    import bus_map_pkg::*;

    // arbiter to targets
    logic      io_wr;
    cpu_data_t io_rdata;
    logic      seq_start;
    logic      seq_done;
    cpu_data_t seq_rdata;

    mem_arbiter arb0 (
        .clk_sys     (clk_sys),
        .reset_n     (reset_n),
        .cpu_valid_i (cpu_valid_i),
        .cpu_addr_i  (cpu_addr_i),
        .cpu_wstrb_i (cpu_wstrb_i),
        .rom_data_i  (rom_data_i),
        .io_rdata_i  (io_rdata),
        .seq_done_i  (seq_done),
        .seq_rdata_i (seq_rdata),
        .cpu_ready_o (cpu_ready_o),
        .cpu_rdata_o (cpu_rdata_o),
        .seq_start_o (seq_start),
        .io_wr_o     (io_wr)
    );

    // sequencer sees the cpu bus directly, master holds it steady
    sdram_halfword_seq seq0 (
        .clk_sys       (clk_sys),
        .reset_n       (reset_n),
        .seq_start_i   (seq_start),
        .cpu_addr_i    (cpu_addr_i),
        .cpu_wdata_i   (cpu_wdata_i),
        .cpu_wstrb_i   (cpu_wstrb_i),
        .sdram_rdata_i (sdram_rdata_i),
        .sdram_rdy_i   (sdram_rdy_i),
        .seq_done_o    (seq_done),
        .seq_rdata_o   (seq_rdata),
        .sdram_rd_o    (sdram_rd_o),
        .sdram_wr_o    (sdram_wr_o),
        .sdram_addr_o  (sdram_addr_o),
        .sdram_wdata_o (sdram_wdata_o),
        .sdram_ack_o   (sdram_ack_o)
    );

    // register offset is the low 12 address bits
    io_regs io0 (
        .clk_sys          (clk_sys),
        .reset_n          (reset_n),
        .io_wr_i          (io_wr),
        .io_offset_i      (cpu_addr_i[11:0]),
        .io_wdata_i       (cpu_wdata_i),
        .uart_busy_i      (uart_busy_i),
        .io_rdata_o       (io_rdata),
        .uart_wr_strobe_o (uart_wr_strobe_o),
        .uart_data_o      (uart_data_o),
        .led_o            (led_o),
        .bg_color_o       (bg_color_o)
    );

endmodule

// File: sim/clk_gen.sv
`timescale 1ns/1ps

module clk_gen #(
    parameter int reset_cycles = 2
) (
    output logic clk_sys_o,
    output logic reset_n_o
);

    // 10 ns period
    initial begin
        clk_sys_o = 1'b0;
        forever #5 clk_sys_o = ~clk_sys_o;
    end

    // reset held low over the first rising edges
    initial begin
        reset_n_o = 1'b0;
        repeat (reset_cycles) @(posedge clk_sys_o);
        reset_n_o <= 1'b1;
    end

endmodule

// File: sim/sdram_model.sv
`timescale 1ns/1ps

module sdram_model #(
    parameter logic [31:0] seed_init = 32'h0
) (
    input  logic                        clk_sys,
    input  logic                        reset_n,
    input  logic                        sdram_rd_i,
    input  logic                        sdram_wr_i,
    input  sdram_xfer_pkg::sdram_addr_t sdram_addr_i,
    input  sdram_xfer_pkg::half_t       sdram_wdata_i,
    output sdram_xfer_pkg::half_t       sdram_rdata_o,
    output logic                        sdram_rdy_o
);
    import sdram_xfer_pkg::*;

    // 256 halfwords, low address bits only
    half_t       mem [0:255];
    integer      seed;
    logic [31:0] draw;
    logic        level_q;
    logic [2:0]  wait_cnt;

    // fill depends on every index bit
    initial begin
        seed        = seed_init;
        sdram_rdy_o = 1'b1;
        for (int i = 0; i < 256; i++) begin
            mem[i] = {i[7:0] ^ 8'h5a, ~i[7:0]};
        end
    end

    // read data follows the address while the level is up
    assign sdram_rdata_o = mem[sdram_addr_i[7:0]];

    always @(posedge clk_sys) begin
        level_q <= sdram_rd_i || sdram_wr_i;
        if (!reset_n) begin
            sdram_rdy_o <= 1'b1;
            wait_cnt    <= 3'd0;
            level_q     <= 1'b0;
        end else if ((sdram_rd_i || sdram_wr_i) && !level_q) begin
            // new transfer, busy for 1 to 4 cycles
            draw = $random(seed);
            sdram_rdy_o <= 1'b0;
            wait_cnt    <= 3'd1 + {1'b0, draw[1:0]};
        end else if (wait_cnt != 3'd0) begin
            wait_cnt <= wait_cnt - 3'd1;
            if (wait_cnt == 3'd1) begin
                // write lands as rdy comes back
                sdram_rdy_o <= 1'b1;
                if (sdram_wr_i) begin
                    mem[sdram_addr_i[7:0]] <= sdram_wdata_i;
                end
            end
        end
    end

endmodule

// File: sim/tb_mem_bridge.sv
`timescale 1ns/1ps

module tb_mem_bridge;
    import bus_map_pkg::*;
    import sdram_xfer_pkg::*;

    localparam int          num_tests      = 13;
    localparam int          access_timeout = 100;
    localparam int          reset_timeout  = 20;
    localparam int          tail_cycles    = 3;
    localparam logic [31:0] rand_seed      = 32'h0655bf60;
    // rom word is the address xor this
    localparam cpu_data_t   rom_pattern    = 32'h5a5a_c3c3;

    // one row of the stimulus table
    typedef struct packed {
        mem_target_t target;
        logic        busy;
        cpu_addr_t   addr;
        cpu_wstrb_t  wstrb;
        cpu_data_t   wdata;
        cpu_data_t   exp_rdata;
        cpu_data_t   exp_side;
    } entry_t;

    logic        clk_sys;
    logic        reset_n;
    logic        cpu_valid_i;
    cpu_addr_t   cpu_addr_i;
    cpu_data_t   cpu_wdata_i;
    cpu_wstrb_t  cpu_wstrb_i;
    cpu_data_t   rom_data_i;
    logic        uart_busy_i;
    half_t       sdram_rdata_i;
    logic        sdram_rdy_i;
    logic        cpu_ready_o;
    cpu_data_t   cpu_rdata_o;
    logic        uart_wr_strobe_o;
    logic [7:0]  uart_data_o;
    logic [7:0]  led_o;
    logic [23:0] bg_color_o;
    logic        sdram_rd_o;
    logic        sdram_wr_o;
    sdram_addr_t sdram_addr_o;
    half_t       sdram_wdata_o;
    logic        sdram_ack_o;

    entry_t    test_table [0:num_tests-1];
    string     test_name  [0:num_tests-1];
    int        n_entries;
    int        errors;
    int        checks;
    int        errs_before;
    // results of the last access
    cpu_data_t got_rdata;
    int        ready_pulses;
    int        strobe_pulses;
    int        ack_pulses;
    logic      timed_out;

    clk_gen clk0 (
        .clk_sys_o (clk_sys),
        .reset_n_o (reset_n)
    );

    mem_bridge_top dut0 (
        .clk_sys          (clk_sys),
        .reset_n          (reset_n),
        .cpu_valid_i      (cpu_valid_i),
        .cpu_addr_i       (cpu_addr_i),
        .cpu_wdata_i      (cpu_wdata_i),
        .cpu_wstrb_i      (cpu_wstrb_i),
        .rom_data_i       (rom_data_i),
        .uart_busy_i      (uart_busy_i),
        .sdram_rdata_i    (sdram_rdata_i),
        .sdram_rdy_i      (sdram_rdy_i),
        .cpu_ready_o      (cpu_ready_o),
        .cpu_rdata_o      (cpu_rdata_o),
        .uart_wr_strobe_o (uart_wr_strobe_o),
        .uart_data_o      (uart_data_o),
        .led_o            (led_o),
        .bg_color_o       (bg_color_o),
        .sdram_rd_o       (sdram_rd_o),
        .sdram_wr_o       (sdram_wr_o),
        .sdram_addr_o     (sdram_addr_o),
        .sdram_wdata_o    (sdram_wdata_o),
        .sdram_ack_o      (sdram_ack_o)
    );

    sdram_model #(
        .seed_init (rand_seed)
    ) sdram0 (
        .clk_sys       (clk_sys),
        .reset_n       (reset_n),
        .sdram_rd_i    (sdram_rd_o),
        .sdram_wr_i    (sdram_wr_o),
        .sdram_addr_i  (sdram_addr_o),
        .sdram_wdata_i (sdram_wdata_o),
        .sdram_rdata_o (sdram_rdata_i),
        .sdram_rdy_o   (sdram_rdy_i)
    );

    // boot rom stand-in
    assign rom_data_i = cpu_addr_i ^ rom_pattern;

    function automatic cpu_data_t rom_word(input cpu_addr_t addr);
        return addr ^ rom_pattern;
    endfunction

    task automatic check_word(input string name, input cpu_data_t got, input cpu_data_t exp);
        checks++;
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_half(input string name, input half_t got, input half_t exp);
        checks++;
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_color(input string name, input logic [23:0] got,
                               input logic [23:0] exp);
        checks++;
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    // pulse counts seen over one access
    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic add_entry(input string name, input mem_target_t target, input logic busy,
                             input cpu_addr_t addr, input cpu_wstrb_t wstrb,
                             input cpu_data_t wdata, input cpu_data_t exp_rdata,
                             input cpu_data_t exp_side);
        test_table[n_entries] = {target, busy, addr, wstrb, wdata, exp_rdata, exp_side};
        test_name[n_entries]  = name;
        n_entries++;
    endtask

    // expected values follow the bridge rules
    task automatic build_table();
        cpu_word_u   shadow;
        cpu_word_u   wr;
        logic [23:0] color;
        n_entries = 0;
        color     = 24'd0;
        add_entry("rom read", target_bootrom, 1'b0, 32'h0000_0040, 4'b0000, '0,
                  rom_word(32'h0000_0040), '0);
        // trace byte is the low byte
        wr.word = 32'h1234_56a5;
        add_entry("trace write", target_io, 1'b0, io_space_base | io_off_trace,
                  wstrb_full, wr.word, '0, {24'd0, wr.word[7:0]});
        // nonzero colour loads its low 24 bits
        wr.word = 32'hff12_3456;
        if (wr.word != '0) begin
            color = wr.word[23:0];
        end
        add_entry("colour write", target_io, 1'b0, io_space_base | io_off_bg_color,
                  wstrb_full, wr.word, '0, {8'd0, color});
        wr.word = 32'h0000_0000;
        if (wr.word != '0) begin
            color = wr.word[23:0];
        end
        add_entry("colour zero write", target_io, 1'b0, io_space_base | io_off_bg_color,
                  wstrb_full, wr.word, '0, {8'd0, color});
        // status word, busy in bit 0
        add_entry("status busy low", target_io, 1'b0, io_space_base | 32'h8, 4'b0000, '0,
                  {31'd0, 1'b0}, '0);
        add_entry("status busy high", target_io, 1'b1, io_space_base | 32'h8, 4'b0000, '0,
                  {31'd0, 1'b1}, '0);
        shadow.word = 32'hcafe_1234;
        add_entry("sdram word write", target_sdram, 1'b0, 32'h4000_0010, wstrb_full,
                  shadow.word, '0, shadow.word);
        add_entry("sdram word read", target_sdram, 1'b0, 32'h4000_0010, 4'b0000, '0,
                  shadow.word, '0);
        // halfword writes touch only their own half
        wr.word = 32'h1111_beef;
        shadow.halves.lo = wr.halves.lo;
        add_entry("sdram low half write", target_sdram, 1'b0, 32'h4000_0010, wstrb_lo_half,
                  wr.word, '0, shadow.word);
        wr.word = 32'h7777_2222;
        shadow.halves.hi = wr.halves.hi;
        add_entry("sdram high half write", target_sdram, 1'b0, 32'h4000_0010, wstrb_hi_half,
                  wr.word, '0, shadow.word);
        add_entry("sdram merged read", target_sdram, 1'b0, 32'h4000_0010, 4'b0000, '0,
                  shadow.word, '0);
        // rom ignores writes but still answers
        add_entry("rom write", target_bootrom, 1'b0, 32'h0000_0100, wstrb_full,
                  32'hdead_beef, '0, '0);
        add_entry("rom read again", target_bootrom, 1'b0, 32'h0000_0abc, 4'b0000, '0,
                  rom_word(32'h0000_0abc), '0);
    endtask

    // one bus access, drive on posedge, sample on negedge
    task automatic run_access(input entry_t e);
        int   cycles;
        logic seen;
        cycles        = 0;
        seen          = 1'b0;
        ready_pulses  = 0;
        strobe_pulses = 0;
        ack_pulses    = 0;
        @(posedge clk_sys);
        cpu_valid_i <= 1'b1;
        cpu_addr_i  <= e.addr;
        cpu_wdata_i <= e.wdata;
        cpu_wstrb_i <= e.wstrb;
        uart_busy_i <= e.busy;
        while (!seen && cycles < access_timeout) begin
            @(negedge clk_sys);
            cycles++;
            if (uart_wr_strobe_o) begin
                strobe_pulses++;
            end
            if (sdram_ack_o) begin
                ack_pulses++;
            end
            if (cpu_ready_o) begin
                seen = 1'b1;
                ready_pulses++;
                got_rdata = cpu_rdata_o;
            end
        end
        timed_out = !seen;
        // master drops valid after ready
        @(posedge clk_sys);
        cpu_valid_i <= 1'b0;
        cpu_wstrb_i <= '0;
        // watch for extra pulses
        repeat (tail_cycles) begin
            @(negedge clk_sys);
            if (cpu_ready_o) begin
                ready_pulses++;
            end
            if (uart_wr_strobe_o) begin
                strobe_pulses++;
            end
            if (sdram_ack_o) begin
                ack_pulses++;
            end
        end
    endtask

    task automatic run_test(input int idx);
        entry_t     e;
        cpu_word_u  exp_u;
        logic [7:0] half_idx;
        int         exp_strobes;
        int         exp_acks;
        e           = test_table[idx];
        exp_u.word  = e.exp_side;
        // low half even, high half odd
        half_idx    = {e.addr[8:2], 1'b0};
        exp_strobes = 0;
        if (e.target == target_io && e.wstrb != '0 && e.addr[11:0] == io_off_trace) begin
            exp_strobes = 1;
        end
        // one ack between the halves of a word, one after done
        exp_acks = 0;
        if (e.target == target_sdram) begin
            if (e.wstrb == 4'b0011 || e.wstrb == 4'b1100) begin
                exp_acks = 1;
            end else begin
                exp_acks = 2;
            end
        end
        run_access(e);
        if (timed_out) begin
            $display("test %0d: no cpu_ready_o within %0d cycles", idx, access_timeout);
            errors++;
        end else begin
            check_count("cpu_ready_o pulses", ready_pulses, 1);
            check_count("uart_wr_strobe_o pulses", strobe_pulses, exp_strobes);
            check_count("sdram_ack_o pulses", ack_pulses, exp_acks);
            if (e.wstrb == '0) begin
                check_word("cpu_rdata_o", got_rdata, e.exp_rdata);
            end
            if (e.target == target_io && e.wstrb != '0) begin
                if (exp_strobes == 1) begin
                    check_byte("uart_data_o", uart_data_o, exp_u.word[7:0]);
                    check_byte("led_o", led_o, exp_u.word[7:0]);
                end else begin
                    check_color("bg_color_o", bg_color_o, exp_u.word[23:0]);
                end
            end
            if (e.target == target_sdram && e.wstrb != '0) begin
                check_half("sdram low half", sdram0.mem[half_idx], exp_u.halves.lo);
                check_half("sdram high half", sdram0.mem[half_idx | 8'd1], exp_u.halves.hi);
            end
        end
    endtask

    task automatic wait_reset();
        int cycles;
        cycles = 0;
        while (reset_n !== 1'b1 && cycles < reset_timeout) begin
            @(posedge clk_sys);
            cycles++;
        end
        if (reset_n !== 1'b1) begin
            $display("reset_n stayed low for %0d cycles", reset_timeout);
            errors++;
        end
        @(negedge clk_sys);
    endtask

    initial begin
        cpu_valid_i = 1'b0;
        cpu_addr_i  = '0;
        cpu_wdata_i = '0;
        cpu_wstrb_i = '0;
        uart_busy_i = 1'b0;
        errors      = 0;
        checks      = 0;
        build_table();
        wait_reset();

        // idle outputs after reset
        errs_before = errors;
        check_bit("cpu_ready_o", cpu_ready_o, 1'b0);
        check_bit("uart_wr_strobe_o", uart_wr_strobe_o, 1'b0);
        check_bit("sdram_rd_o", sdram_rd_o, 1'b0);
        check_bit("sdram_wr_o", sdram_wr_o, 1'b0);
        check_bit("sdram_ack_o", sdram_ack_o, 1'b0);
        check_color("bg_color_o", bg_color_o, 24'd0);
        if (errors == errs_before) begin
            $display("reset values: ok");
        end else begin
            $display("reset values: failed");
        end

        for (int i = 0; i < n_entries; i++) begin
            errs_before = errors;
            run_test(i);
            if (errors == errs_before) begin
                $display("test %0d %s: ok", i, test_name[i]);
            end else begin
                $display("test %0d %s: failed", i, test_name[i]);
            end
        end

        $display("%0d tests, %0d checks, %0d errors", n_entries, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: mem_bridge.f
src/bus_map_pkg.sv
src/sdram_xfer_pkg.sv
src/mem_arbiter.sv
src/sdram_halfword_seq.sv
src/io_regs.sv
src/mem_bridge_top.sv
sim/clk_gen.sv
sim/sdram_model.sv
sim/tb_mem_bridge.sv
